//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
    --top-module tb_eeprom_ctrl -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/eeprom_req_stage.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/eeprom_ctrl_sva.sv
verif/tb_eeprom_ctrl.sv

//--- verif/eeprom_ctrl_sva.sv
module eeprom_ctrl_sva (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                busy,
    input  logic                op_valid,
    input  logic                op_done,
    input  eeprom_pkg::bus_op_e code_q,
    input  logic                scl,
    input  logic                sda_oe
);
    import eeprom_pkg::*;

    // data edges with scl high belong to start and stop only
    sda_stable_a: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_oe) && scl && $past(scl)) |-> (code_q == OP_START || code_q == OP_STOP))
        else $error("sda_oe changed while scl high outside start/stop");

    // sequencer lets go of op_valid while op_done is up
    done_pulse_a: assert property (@(posedge CLK) disable iff (RESET)
        op_done |-> !op_valid ##1 !op_done)
        else $error("op_done not a single-cycle pulse or op_valid held through it");

    idle_bus_a: assert property (@(posedge CLK) disable iff (RESET)
        (!busy && !op_valid && !op_done) |-> (scl && !sda_oe))
        else $error("bus not released while idle");

endmodule

bind eeprom_bit_engine eeprom_ctrl_sva u_sva (
    .CLK      (CLK),
    .RESET    (RESET),
    .busy     (busy),
    .op_valid (op_valid),
    .op_done  (op_done),
    .code_q   (code_q),
    .scl      (scl),
    .sda_oe   (sda_oe)
);

//--- verif/eeprom_model.sv
`include "eeprom_cfg.svh"

// behavioral serial EEPROM slave, single byte writes and random reads only
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic model_refuse,
    output logic sda_oe
);
    import eeprom_pkg::*;

    logic [7:0] mem [0:2047];
    logic [7:0] shreg;
    logic [2:0] block;
    logic [7:0] lo;
    logic [7:0] wr_data;
    logic [7:0] rd_byte;
    logic       active;
    logic       wr_pend;
    logic       rd_armed;
    logic       reading;
    int         bit_cnt;
    int         byte_idx;
    bus_byte_u  rx;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;    // erased
        sda_oe   = 1'b0;
        active   = 1'b0;
        wr_pend  = 1'b0;
        rd_armed = 1'b0;
        reading  = 1'b0;
        bit_cnt  = 0;
        byte_idx = 0;
        block    = 3'd0;
        lo       = 8'h00;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active   = 1'b1;
            reading  = 1'b0;
            rd_armed = 1'b0;
            wr_pend  = 1'b0;
            bit_cnt  = 0;
            byte_idx = 0;
        end
    end

    // stop commits a pending write
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (wr_pend)
                mem[{block, lo}] = wr_data;
            wr_pend = 1'b0;
            active  = 1'b0;
            reading = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (!reading && bit_cnt < 8)
                shreg = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (reading && bit_cnt >= 1 && bit_cnt <= 7)
                sda_oe = !rd_byte[7 - bit_cnt];
            else if (reading && bit_cnt == 8)
                sda_oe = 1'b0;    // master answers
            else if (reading && bit_cnt == 9)
            begin
                sda_oe  = 1'b0;
                reading = 1'b0;
                active  = 1'b0;
            end
            else if (bit_cnt == 8)
            begin
                rx.data = shreg;
                if (byte_idx == 0)
                begin
                    if (rx.ctrl.device_code == `EE_DEVICE_CODE && !model_refuse)
                    begin
                        sda_oe = 1'b1;
                        block  = rx.ctrl.block;
                        if (rx.ctrl.rw)
                        begin
                            rd_armed = 1'b1;
                            rd_byte  = mem[{rx.ctrl.block, lo}];
                        end
                    end
                    else
                        active = 1'b0;    // no ack, bus left to the master
                end
                else if (byte_idx == 1)
                begin
                    lo     = shreg;
                    sda_oe = 1'b1;
                end
                else
                begin
                    wr_data = shreg;
                    wr_pend = 1'b1;
                    sda_oe  = 1'b1;
                end
                byte_idx = byte_idx + 1;
            end
            else if (bit_cnt == 9)
            begin
                sda_oe  = 1'b0;
                bit_cnt = 0;
                if (rd_armed)
                begin
                    rd_armed = 1'b0;
                    reading  = 1'b1;
                    sda_oe   = !rd_byte[7];
                end
            end
        end
    end

endmodule

//--- verif/tb_eeprom_ctrl.sv
`include "eeprom_cfg.svh"

module tb_eeprom_ctrl;

    localparam int N_RANDOM = 60;
    localparam int N_REQ    = N_RANDOM + 6;
    localparam int LIMIT    = N_REQ * (7 * 9 * 2 * `EE_SCL_HALF + 40);

    logic                  CLK;
    logic                  RESET;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_write;
    logic [`EE_ADDR_W-1:0] req_addr;
    logic [7:0]            req_wdata;
    logic                  resp_valid;
    logic                  resp_ready;
    logic [7:0]            resp_rdata;
    logic                  resp_nack;
    logic                  scl;
    logic                  sda_oe;
    logic                  m_oe;
    logic                  sda_in;
    logic                  model_refuse;

    logic [7:0]  shadow [0:2047];
    logic [9:0]  exp_q [$];    // {check data, nack, rdata}
    logic [15:0] stim_lfsr;
    logic [15:0] stall_lfsr;
    int          value_errors;
    int          other_errors;
    int          checked;
    int          cycles;
    logic [31:0] r;
    logic        w;
    logic [10:0] a;
    logic [10:0] last_wr;
    logic        have_wr;

    assign sda_in = !(sda_oe || m_oe);    // wired-AND of both pull-downs

    eeprom_ctrl_top u_eeprom_ctrl_top (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_nack  (resp_nack),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

    eeprom_model u_model (
        .scl          (scl),
        .sda          (sda_in),
        .model_refuse (model_refuse),
        .sda_oe       (m_oe)
    );

    always #50 CLK = ~CLK;

    // fibonacci with taps 16 14 13 11
    function automatic logic [31:0] take_bits(inout logic [15:0] st, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            st = {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
            v  = {v[30:0], st[0]};
        end
        return v;
    endfunction

    // rdata is only meaningful for an acknowledged read
    function automatic logic [9:0] expected_resp(input logic wr, input logic [10:0] addr,
                                                 input logic refuse);
        if (refuse)
            return {1'b0, 1'b1, 8'h00};
        else if (wr)
            return {1'b0, 1'b0, 8'h00};
        else
            return {1'b1, 1'b0, shadow[addr]};
    endfunction

    task automatic send_req(input logic wr, input logic [10:0] addr, input logic [7:0] d);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = d;
        do
            @(negedge CLK);
        while (!req_ready);
        exp_q.push_back(expected_resp(wr, addr, model_refuse));
        if (wr && !model_refuse)
            shadow[addr] = d;
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge CLK);
        @(posedge CLK);
        #1;
    endtask

    always @(posedge CLK)
    begin : stall_gen
        logic [31:0] s;
        #1;
        s = take_bits(stall_lfsr, 2);
        resp_ready = (s[1:0] != 2'b00);    // low a quarter of the time
    end

    always @(negedge CLK)
    begin : check_resp
        logic [9:0] e;
        if (!RESET && resp_valid && resp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("response arrived with no request outstanding");
            end
            else
            begin
                e = exp_q.pop_front();
                checked++;
                assert (resp_nack === e[8])
                else
                begin
                    value_errors++;
                    $display("FAIL resp_nack got %h expected %h", resp_nack, e[8]);
                end
                if (e[9])
                begin
                    assert (resp_rdata === e[7:0])
                    else
                    begin
                        value_errors++;
                        $display("FAIL resp_rdata got %h expected %h", resp_rdata, e[7:0]);
                    end
                end
            end
        end
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            other_errors++;
            $display("timeout after %0d cycles, responses still missing", cycles);
            $display("errors: %0d value, %0d other, %0d responses checked",
                     value_errors, other_errors, checked);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = 8'h00;
        resp_ready   = 1'b0;
        model_refuse = 1'b0;
        stim_lfsr    = 16'd13;
        stall_lfsr   = 16'd13;
        value_errors = 0;
        other_errors = 0;
        checked      = 0;
        cycles       = 0;
        have_wr      = 1'b0;
        last_wr      = '0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;

        // first request after reset hits unwritten memory
        send_req(1'b0, 11'h5A3, 8'h00);
        drain();
        send_req(1'b1, 11'h2C7, 8'h3E);
        send_req(1'b0, 11'h2C7, 8'h00);
        drain();

        // refused control byte and then normal again
        model_refuse = 1'b1;
        send_req(1'b1, 11'h2C7, 8'hC1);
        drain();
        send_req(1'b0, 11'h2C7, 8'h00);
        drain();
        model_refuse = 1'b0;
        send_req(1'b0, 11'h2C7, 8'h00);
        drain();

        // back-to-back random traffic
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = take_bits(stim_lfsr, 20);
            w = r[0];
            a = r[11:1];
            if (!w && have_wr && take_bits(stim_lfsr, 1) == 32'd1)
                a = last_wr;    // read back something written
            send_req(w, a, r[19:12]);
            if (w)
            begin
                last_wr = a;
                have_wr = 1'b1;
            end
        end
        drain();
        repeat (20) @(posedge CLK);

        // bus released and both handshakes idle
        assert ({scl, sda_oe, req_ready, resp_valid} === 4'b1010)
        else
        begin
            value_errors++;
            $display("FAIL {scl,sda_oe,req_ready,resp_valid} got %h expected %h",
                     {scl, sda_oe, req_ready, resp_valid}, 4'b1010);
        end

        $display("errors: %0d value, %0d other, %0d responses checked",
                 value_errors, other_errors, checked);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- verilog/eeprom_bit_engine.sv
`include "eeprom_cfg.svh"

module eeprom_bit_engine (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_valid,
    input  eeprom_pkg::bus_op_e op_code,
    input  logic [7:0]          op_tx_byte,
    input  logic                op_ack_out,
    output logic                op_done,
    output logic [7:0]          op_rx_byte,
    output logic                op_ack_in,
    output logic                scl,
    output logic                sda_oe,
    input  logic                sda_in
);
    import eeprom_pkg::*;

    localparam int QUARTER = `EE_SCL_HALF / 2;
    localparam int PH_W    = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    logic            busy;
    bus_op_e         code_q;
    logic [PH_W-1:0] phase;
    logic [5:0]      step;       // quarter steps, 4 per bit
    logic [7:0]      shift_q;

    logic            accept;
    logic            step_end;
    logic            op_end;
    logic            enter;
    logic [5:0]      enter_step;
    bus_op_e         cur_code;
    logic            is_byte;
    logic [5:0]      last_step;
    logic [1:0]      quarter;
    logic [3:0]      bit_idx;
    logic            tx_bit;

    assign accept     = !busy && op_valid;
    assign cur_code   = busy ? code_q : op_code;
    assign is_byte    = (cur_code == OP_WRITE) || (cur_code == OP_READ);
    assign last_step  = is_byte ? 6'd35 : 6'd7;    // 9 bits or 2 bits
    assign step_end   = busy && (phase == PH_W'(QUARTER - 1));
    assign op_end     = step_end && (step == last_step);
    assign enter      = accept || (step_end && !op_end);
    assign enter_step = accept ? 6'd0 : step + 6'd1;
    assign quarter    = enter_step[1:0];
    assign bit_idx    = enter_step[5:2];
    assign tx_bit     = busy ? shift_q[7] : op_tx_byte[7];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            phase   <= '0;
            step    <= '0;
        end
        else
        begin
            op_done <= op_end;
            if (accept)
            begin
                busy  <= 1'b1;
                phase <= '0;
                step  <= '0;
            end
            else if (step_end)
            begin
                phase <= '0;
                step  <= enter_step;
                busy  <= !op_end;
            end
            else if (busy)
                phase <= phase + PH_W'(1);
        end
    end

    // per bit: sda set, scl up, sample, scl down
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else if (enter && is_byte)
        begin
            case (quarter)
                2'd0:
                begin
                    if (bit_idx == 4'd8)
                        sda_oe <= (cur_code == OP_READ) && !op_ack_out;
                    else
                        sda_oe <= (cur_code == OP_WRITE) && !tx_bit;
                end
                2'd1:    scl <= 1'b1;
                2'd3:    scl <= 1'b0;
                default: ;
            endcase
        end
        else if (enter)
        begin
            case (enter_step)
                6'd0:    sda_oe <= (cur_code == OP_STOP);     // start releases, stop pulls
                6'd2:    scl <= 1'b1;
                6'd4:    sda_oe <= (cur_code == OP_START);    // the actual start/stop edge
                6'd6:    scl <= (cur_code == OP_STOP);
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            code_q  <= op_code;
            shift_q <= op_tx_byte;
        end
        else if (enter && is_byte && quarter == 2'd2)
        begin
            if (bit_idx == 4'd8)
                op_ack_in <= sda_in;    // low = acked
            else
                op_rx_byte <= {op_rx_byte[6:0], sda_in};
        end
        else if (enter && is_byte && quarter == 2'd3)
            shift_q <= {shift_q[6:0], 1'b0};
    end

endmodule

//--- verilog/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// byte address into the 2048-byte array
`define EE_ADDR_W 11

`define EE_DEVICE_CODE 4'b1010

// CLK cycles per SCL half period, even and at least 2
`define EE_SCL_HALF 4

`endif

//--- verilog/eeprom_ctrl_top.sv
`include "eeprom_cfg.svh"

module eeprom_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [`EE_ADDR_W-1:0] req_addr,
    input  logic [7:0]            req_wdata,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [7:0]            resp_rdata,
    output logic                  resp_nack,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  cmd_write;
    logic [`EE_ADDR_W-1:0] cmd_addr;
    logic [7:0]            cmd_wdata;

    logic                  op_valid;
    bus_op_e               op_code;
    logic [7:0]            op_tx_byte;
    logic                  op_ack_out;
    logic                  op_done;
    logic [7:0]            op_rx_byte;
    logic                  op_ack_in;

    eeprom_req_stage u_req_stage (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata)
    );

    eeprom_sequencer u_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_tx_byte (op_tx_byte),
        .op_ack_out (op_ack_out),
        .op_done    (op_done),
        .op_rx_byte (op_rx_byte),
        .op_ack_in  (op_ack_in),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_nack  (resp_nack)
    );

    // bus pins go straight out, the wired-AND is outside
    eeprom_bit_engine u_bit_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_tx_byte (op_tx_byte),
        .op_ack_out (op_ack_out),
        .op_done    (op_done),
        .op_rx_byte (op_rx_byte),
        .op_ack_in  (op_ack_in),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

//--- verilog/eeprom_pkg.sv
package eeprom_pkg;

    // what the sequencer asks of the bit engine
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } bus_op_e;

    // first byte after a start, msb goes out first
    typedef struct packed {
        logic [3:0] device_code;
        logic [2:0] block;    // address bits 10..8
        logic       rw;       // 1 = read
    } ctrl_byte_t;

    // one byte on the wire, seen as control or as plain data
    typedef union packed {
        ctrl_byte_t ctrl;
        logic [7:0] data;
    } bus_byte_u;

endpackage

//--- verilog/eeprom_req_stage.sv
`include "eeprom_cfg.svh"

module eeprom_req_stage (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_write,
    input  logic [`EE_ADDR_W-1:0] req_addr,
    input  logic [7:0]            req_wdata,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output logic                  cmd_write,
    output logic [`EE_ADDR_W-1:0] cmd_addr,
    output logic [7:0]            cmd_wdata
);

    logic full;
    logic accept;

    // room when empty or when the held request leaves this cycle
    assign req_ready = !full || cmd_ready;
    assign accept    = req_valid && req_ready;
    assign cmd_valid = full;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            full <= 1'b0;
        else if (accept)
            full <= 1'b1;
        else if (cmd_ready)
            full <= 1'b0;    // drained
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_write <= req_write;
            cmd_addr  <= req_addr;
            cmd_wdata <= req_wdata;
        end
    end

endmodule

//--- verilog/eeprom_sequencer.sv
`include "eeprom_cfg.svh"

module eeprom_sequencer (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  cmd_write,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [7:0]            cmd_wdata,
    output logic                  op_valid,
    output eeprom_pkg::bus_op_e   op_code,
    output logic [7:0]            op_tx_byte,
    output logic                  op_ack_out,
    input  logic                  op_done,
    input  logic [7:0]            op_rx_byte,
    input  logic                  op_ack_in,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [7:0]            resp_rdata,
    output logic                  resp_nack
);
    import eeprom_pkg::*;

    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_START   = 4'd1;
    localparam logic [3:0] S_CTRL_WR = 4'd2;
    localparam logic [3:0] S_ADDR    = 4'd3;
    localparam logic [3:0] S_DATA_WR = 4'd4;
    localparam logic [3:0] S_RESTART = 4'd5;
    localparam logic [3:0] S_CTRL_RD = 4'd6;
    localparam logic [3:0] S_DATA_RD = 4'd7;
    localparam logic [3:0] S_STOP    = 4'd8;
    localparam logic [3:0] S_RESP    = 4'd9;

    logic [3:0]            state;
    logic                  nack_q;
    logic                  write_q;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [7:0]            wdata_q;
    logic [7:0]            rdata_q;
    bus_byte_u             tx_q;
    logic                  cmd_take;

    function automatic bus_byte_u ctrl_byte(input logic [2:0] block, input logic rw);
        bus_byte_u b;
        b.ctrl.device_code = `EE_DEVICE_CODE;
        b.ctrl.block       = block;
        b.ctrl.rw          = rw;
        return b;
    endfunction

    assign cmd_ready  = (state == S_IDLE);
    assign cmd_take   = cmd_valid && cmd_ready;
    assign op_valid   = (state != S_IDLE) && (state != S_RESP) && !op_done;
    assign op_tx_byte = tx_q.data;
    assign op_ack_out = 1'b1;    // single byte reads always end in NACK
    assign resp_valid = (state == S_RESP);
    assign resp_rdata = rdata_q;
    assign resp_nack  = nack_q;

    always_comb
    begin
        case (state)
            S_START, S_RESTART: op_code = OP_START;
            S_DATA_RD:          op_code = OP_READ;
            S_STOP:             op_code = OP_STOP;
            default:            op_code = OP_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            nack_q <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:    state <= cmd_take ? S_START : S_IDLE;
                S_START:   state <= op_done ? S_CTRL_WR : S_START;
                S_CTRL_WR: state <= !op_done ? S_CTRL_WR : (op_ack_in ? S_STOP : S_ADDR);
                S_ADDR:
                begin
                    if (op_done)
                        state <= op_ack_in ? S_STOP : (write_q ? S_DATA_WR : S_RESTART);
                end
                S_DATA_WR: state <= op_done ? S_STOP : S_DATA_WR;
                S_RESTART: state <= op_done ? S_CTRL_RD : S_RESTART;
                S_CTRL_RD: state <= !op_done ? S_CTRL_RD : (op_ack_in ? S_STOP : S_DATA_RD);
                S_DATA_RD: state <= op_done ? S_STOP : S_DATA_RD;
                S_STOP:    state <= op_done ? S_RESP : S_STOP;
                S_RESP:    state <= resp_ready ? S_IDLE : S_RESP;
                default:   state <= S_IDLE;
            endcase
            if (cmd_take)
                nack_q <= 1'b0;
            else if (op_done && op_code == OP_WRITE && op_ack_in)
                nack_q <= 1'b1;    // keeps the first refusal
        end
    end

    // transmit byte is reloaded as each operation finishes
    always_ff @(posedge CLK)
    begin
        if (cmd_take)
        begin
            write_q <= cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
            rdata_q <= 8'h00;    // zero unless a read completes
            tx_q    <= ctrl_byte(cmd_addr[`EE_ADDR_W-1:8], 1'b0);
        end
        else if (op_done)
        begin
            case (state)
                S_CTRL_WR: tx_q.data <= addr_q[7:0];
                S_ADDR:
                begin
                    if (write_q)
                        tx_q.data <= wdata_q;
                    else
                        tx_q <= ctrl_byte(addr_q[`EE_ADDR_W-1:8], 1'b1);
                end
                S_DATA_RD: rdata_q <= op_rx_byte;
                default: ;
            endcase
        end
    end

endmodule
